// File: Makefile
# Verilator build and run for the alarm/timer unit testbench

VERILATOR ?= verilator
TOP       ?= tbAts21
FILELIST  ?= ats21Top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: alarmBank.sv
// alarm records, target compare, timer target sum and two-cycle finish hold
`include "ats21_cfg.svh"

module alarmBank (
  input  logic                                          clk_1x,
  input  logic                                          reset,
  input  logic                                          alarmWrA,
  input  logic                                          alarmWrB,
  input  ats21Pkg::instrWordT                           wordA,
  input  ats21Pkg::instrWordT                           wordB,
  input  logic [`ATS_NUM_CLOCKS*`ATS_COUNT_WIDTH-1:0]   counts,
  input  logic [`ATS_NUM_CLOCKS-1:0]                    tickNow,
  output logic [`ATS_NUM_ALARMS-1:0]                    data
);

  localparam int HoldWidth = $clog2(`ATS_FINISH_HOLD + 1);

  logic [`ATS_COUNT_WIDTH-1:0]     cntArr [`ATS_NUM_CLOCKS];   // unflattened counts
  logic [`ATS_NUM_ALARMS-1:0]      enQ;
  logic [`ATS_NUM_ALARMS-1:0]      rptQ;
  logic [`ATS_CLOCK_SEL_WIDTH-1:0] selQ   [`ATS_NUM_ALARMS];
  logic [`ATS_COUNT_WIDTH-1:0]     tgtQ   [`ATS_NUM_ALARMS];
  logic [HoldWidth-1:0]            holdQ  [`ATS_NUM_ALARMS];
  logic [`ATS_NUM_ALARMS-1:0]      setA, setB, enWrA, enWrB;
  logic [`ATS_NUM_ALARMS-1:0]      fire;
  logic [`ATS_COUNT_WIDTH-1:0]     tgtA, tgtB;
  logic                            rptA, rptB;

  for (genvar g = 0; g < `ATS_NUM_CLOCKS; g++) begin : genUnpack
    assign cntArr[g] = counts[g*`ATS_COUNT_WIDTH +: `ATS_COUNT_WIDTH];
  end

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  // timer target = live count just before the edge + interval, wraps at 2^16
  assign tgtA = (wordA.alarmView.op == ats21Pkg::setTimer) ?
                `ATS_COUNT_WIDTH'(cntArr[wordA.alarmView.clockSel] + wordA.alarmView.value) :
                wordA.alarmView.value;
  assign tgtB = (wordB.alarmView.op == ats21Pkg::setTimer) ?
                `ATS_COUNT_WIDTH'(cntArr[wordB.alarmView.clockSel] + wordB.alarmView.value) :
                wordB.alarmView.value;
  assign rptA = (wordA.alarmView.op == ats21Pkg::setAlarm) && wordA.alarmView.repeatEn;
  assign rptB = (wordB.alarmView.op == ats21Pkg::setAlarm) && wordB.alarmView.repeatEn;

  always_comb begin
    for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
      setA[i]  = alarmWrA && (wordA.alarmView.op != ats21Pkg::enableAlarm) &&
                 (wordA.alarmView.alarmNum == `ATS_ALARM_SEL_WIDTH'(i));
      setB[i]  = alarmWrB && (wordB.alarmView.op != ats21Pkg::enableAlarm) &&
                 (wordB.alarmView.alarmNum == `ATS_ALARM_SEL_WIDTH'(i));
      enWrA[i] = alarmWrA && (wordA.alarmView.op == ats21Pkg::enableAlarm) &&
                 (wordA.alarmView.alarmNum == `ATS_ALARM_SEL_WIDTH'(i));
      enWrB[i] = alarmWrB && (wordB.alarmView.op == ats21Pkg::enableAlarm) &&
                 (wordB.alarmView.alarmNum == `ATS_ALARM_SEL_WIDTH'(i));
      // hit when the selected counter steps onto the target
      fire[i]  = enQ[i] && tickNow[selQ[i]] &&
                 (`ATS_COUNT_WIDTH'(cntArr[selQ[i]] + 1'b1) == tgtQ[i]);
    end
  end

  ////////////////////////////////////////////////////////////
  // alarm state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      enQ  <= '0;
      rptQ <= '0;
      for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
        holdQ[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
        // enable: a set arms the alarm, one-shot drops on fire
        if (setA[i] || setB[i]) begin
          enQ[i]  <= 1'b1;
          rptQ[i] <= setA[i] ? rptA : rptB;
        end else if (enWrA[i]) begin
          enQ[i]  <= wordA.alarmView.repeatEn;
        end else if (enWrB[i]) begin
          enQ[i]  <= wordB.alarmView.repeatEn;
        end else if (fire[i] && !rptQ[i]) begin
          enQ[i]  <= 1'b0;
        end
        // finished hold counter
        if (setA[i] || setB[i]) begin
          holdQ[i] <= '0;                              // set clears data bit
        end else if (fire[i]) begin
          holdQ[i] <= HoldWidth'(`ATS_FINISH_HOLD);
        end else if (holdQ[i] != '0) begin
          holdQ[i] <= holdQ[i] - 1'b1;
        end
      end
    end
  end

  // counter select and target, payload only
  always_ff @(posedge clk_1x) begin
    for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
      if (setA[i]) begin
        selQ[i] <= wordA.alarmView.clockSel;
        tgtQ[i] <= tgtA;
      end else if (setB[i]) begin
        selQ[i] <= wordB.alarmView.clockSel;
        tgtQ[i] <= tgtB;
      end
    end
  end

  for (genvar g = 0; g < `ATS_NUM_ALARMS; g++) begin : genData
    assign data[g] = holdQ[g] != '0;

    // finished pulse is exactly the hold length
    holdLimit : assert property (@(posedge clk_1x) disable iff (reset)
      $rose(data[g]) |-> ##`ATS_FINISH_HOLD !data[g]);
  end

endmodule

// File: ats21Control.sv
// half-word capture, decode, A/B conflict check, write strobes and status
`include "ats21_cfg.svh"

module ats21Control (
  input  logic                       clk_1x,
  input  logic                       reset,
  input  logic                       req,
  input  logic [`ATS_HALF_WIDTH-1:0] ctrlA,
  input  logic [`ATS_HALF_WIDTH-1:0] ctrlB,
  output logic [1:0]                 stat,
  output logic                       clockWrA,
  output logic                       clockWrB,
  output logic                       alarmWrA,
  output logic                       alarmWrB,
  output ats21Pkg::instrWordT        wordA,
  output ats21Pkg::instrWordT        wordB
);

  // index 0 is client A, index 1 is client B
  logic [`ATS_HALF_WIDTH-1:0] half  [2];
  logic [`ATS_HALF_WIDTH-1:0] upper [2];   // first half held here
  logic [1:0]                 pend;        // upper half waiting
  logic [1:0]                 capture;
  ats21Pkg::instrWordT        word  [2];
  ats21Pkg::opcodeT           op    [2];
  logic [1:0]                 isClk;       // executing a clock op
  logic [1:0]                 isAlm;       // executing an alarm op
  logic [1:0]                 accept;
  logic                       sameClk;
  logic                       sameAlm;
  logic                       conflict;

  assign half[0] = ctrlA;
  assign half[1] = ctrlB;

  ////////////////////////////////////////////////////////////
  // capture of the two halves
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      // first half only with req, nothing pending, non-nop opcode
      capture[c] = req && !pend[c] &&
                   (half[c][`ATS_HALF_WIDTH-1 -: `ATS_OPCODE_WIDTH] != ats21Pkg::nop);
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      pend <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (pend[c]) begin
          pend[c] <= 1'b0;         // lower half taken, req ignored
        end else if (capture[c]) begin
          pend[c] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_1x) begin
    for (int c = 0; c < 2; c++) begin
      if (capture[c]) begin
        upper[c] <= half[c];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // decode and conflict rule
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      word[c]  = {upper[c], half[c]};      // upper ++ live lower half
      op[c]    = word[c].clockView.op;
      isClk[c] = pend[c] && ((op[c] == ats21Pkg::setClock) ||
                             (op[c] == ats21Pkg::enableClock));
      isAlm[c] = pend[c] && ((op[c] == ats21Pkg::setAlarm) ||
                             (op[c] == ats21Pkg::setTimer) ||
                             (op[c] == ats21Pkg::enableAlarm));
    end
  end

  assign sameClk  = word[0].clockView.clockNum == word[1].clockView.clockNum;
  assign sameAlm  = word[0].alarmView.alarmNum == word[1].alarmView.alarmNum;
  // alarm and timer may mix, only the alarm number counts
  assign conflict = (&isClk && sameClk) || (&isAlm && sameAlm);

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      accept[c] = (isClk[c] || isAlm[c]) && !conflict;   // setMode, 100, nop fall out
    end
  end

  // strobes live for the execute cycle only
  assign clockWrA = accept[0] && isClk[0];
  assign clockWrB = accept[1] && isClk[1];
  assign alarmWrA = accept[0] && isAlm[0];
  assign alarmWrB = accept[1] && isAlm[1];
  assign wordA    = word[0];
  assign wordB    = word[1];

  // registered status, ack pulse after execute edge
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      stat <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        stat[c] <= accept[c] ? ats21Pkg::ack : ats21Pkg::nack;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a write needs the first half to have come in with req the edge before
  aWrAfterHalf : assert property (@(posedge clk_1x) disable iff (reset)
    (clockWrA || alarmWrA) |-> $past(req && !pend[0]));
  bWrAfterHalf : assert property (@(posedge clk_1x) disable iff (reset)
    (clockWrB || alarmWrB) |-> $past(req && !pend[1]));

  // the banks rely on never seeing both clients on one target
  noSameClock : assert property (@(posedge clk_1x) disable iff (reset)
    !(clockWrA && clockWrB &&
      (wordA.clockView.clockNum == wordB.clockView.clockNum)));
  noSameAlarm : assert property (@(posedge clk_1x) disable iff (reset)
    !(alarmWrA && alarmWrB &&
      (wordA.alarmView.alarmNum == wordB.alarmView.alarmNum)));

endmodule

// File: ats21Pkg.sv
// opcode, rate and status enums plus the two-view instruction word union
`include "ats21_cfg.svh"

package ats21Pkg;

  typedef enum logic [`ATS_OPCODE_WIDTH-1:0] {
    nop         = `ATS_OP_NOP,
    setClock    = `ATS_OP_SET_CLOCK,
    enableClock = `ATS_OP_EN_CLOCK,
    setMode     = `ATS_OP_SET_MODE,
    setAlarm    = `ATS_OP_SET_ALARM,
    setTimer    = `ATS_OP_SET_TIMER,
    enableAlarm = `ATS_OP_EN_ALARM
  } opcodeT;

  typedef enum logic [`ATS_RATE_WIDTH-1:0] {
    rateEvery   = `ATS_RATE_EVERY,
    rateHalf    = `ATS_RATE_HALF,
    rateQuarter = `ATS_RATE_QUARTER,
    rateRsvd    = `ATS_RATE_RSVD      // never ticks
  } rateT;

  typedef enum logic {
    nack = 1'b0,
    ack  = 1'b1
  } statusT;

  // clock instructions: 001 set, 010 enable
  typedef struct packed {
    opcodeT                          op;        // [31:29]
    logic [`ATS_CLOCK_SEL_WIDTH-1:0] clockNum;  // [28:25]
    logic                            spare;     // [24]
    logic [`ATS_RATE_WIDTH-1:0]      rate;      // [23:22], bit 23 is the enable
    logic [2*`ATS_HALF_WIDTH-`ATS_OPCODE_WIDTH-`ATS_CLOCK_SEL_WIDTH-1
           -`ATS_RATE_WIDTH-`ATS_COUNT_WIDTH-1:0] fill;
    logic [`ATS_COUNT_WIDTH-1:0]     load;      // [15:0]
  } clockViewT;

  // alarm instructions: 101 alarm, 110 timer, 111 enable
  typedef struct packed {
    opcodeT                          op;
    logic [`ATS_ALARM_SEL_WIDTH-1:0] alarmNum;  // [28:24]
    logic                            repeatEn;  // [23] repeat, or enable for 111
    logic [2*`ATS_HALF_WIDTH-`ATS_OPCODE_WIDTH-`ATS_ALARM_SEL_WIDTH-1
           -`ATS_CLOCK_SEL_WIDTH-`ATS_COUNT_WIDTH-1:0] fill;
    logic [`ATS_CLOCK_SEL_WIDTH-1:0] clockSel;  // [19:16]
    logic [`ATS_COUNT_WIDTH-1:0]     value;     // alarm time or interval
  } alarmViewT;

  // one 32-bit word, read either way
  typedef union packed {
    clockViewT clockView;
    alarmViewT alarmView;
  } instrWordT;

endpackage

// File: ats21Top.f
+incdir+.
ats21Pkg.sv
ats21Control.sv
clockBank.sv
alarmBank.sv
ats21Top.sv
tbAts21.sv

// File: ats21Top.sv
// top level of the alarm/timer unit, control beside clock and alarm banks
`include "ats21_cfg.svh"

module ats21Top (
  input  logic                       clk_1x,
  input  logic                       reset,
  input  logic                       req,
  input  logic [`ATS_HALF_WIDTH-1:0] ctrlA,
  input  logic [`ATS_HALF_WIDTH-1:0] ctrlB,
  output logic [1:0]                 stat,       // bit 0 client A, bit 1 client B
  output logic [`ATS_NUM_ALARMS-1:0] data
);

  // control to banks
  logic                clockWrA;
  logic                clockWrB;
  logic                alarmWrA;
  logic                alarmWrB;
  ats21Pkg::instrWordT wordA;
  ats21Pkg::instrWordT wordB;

  // clock bank to alarm bank
  logic [`ATS_NUM_CLOCKS*`ATS_COUNT_WIDTH-1:0] counts;
  logic [`ATS_NUM_CLOCKS-1:0]                  tickNow;

  ats21Control control (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .req      (req),
    .ctrlA    (ctrlA),
    .ctrlB    (ctrlB),
    .stat     (stat),
    .clockWrA (clockWrA),
    .clockWrB (clockWrB),
    .alarmWrA (alarmWrA),
    .alarmWrB (alarmWrB),
    .wordA    (wordA),
    .wordB    (wordB)
  );

  clockBank clocks (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .clockWrA (clockWrA),
    .clockWrB (clockWrB),
    .wordA    (wordA),
    .wordB    (wordB),
    .counts   (counts),
    .tickNow  (tickNow)
  );

  alarmBank alarms (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .alarmWrA (alarmWrA),
    .alarmWrB (alarmWrB),
    .wordA    (wordA),
    .wordB    (wordB),
    .counts   (counts),
    .tickNow  (tickNow),
    .data     (data)
  );

endmodule

// File: ats21_cfg.svh
// widths, counts, opcode encodings and rate codes of the alarm/timer unit
`ifndef ATS21_CFG_SVH
`define ATS21_CFG_SVH

// array sizes
`define ATS_NUM_CLOCKS      16
`define ATS_NUM_ALARMS      24

// field widths
`define ATS_COUNT_WIDTH     16      // counter and alarm value
`define ATS_CLOCK_SEL_WIDTH 4
`define ATS_ALARM_SEL_WIDTH 5
`define ATS_HALF_WIDTH      16      // one instruction half per port
`define ATS_OPCODE_WIDTH    3
`define ATS_RATE_WIDTH      2

// data bit stays up this many cycles
`define ATS_FINISH_HOLD     2

// opcodes, top three bits of the upper half
`define ATS_OP_NOP          3'b000
`define ATS_OP_SET_CLOCK    3'b001
`define ATS_OP_EN_CLOCK     3'b010
`define ATS_OP_SET_MODE     3'b011  // no longer served, always nack
`define ATS_OP_SET_ALARM    3'b101
`define ATS_OP_SET_TIMER    3'b110
`define ATS_OP_EN_ALARM     3'b111

// counter rates
`define ATS_RATE_EVERY      2'b00
`define ATS_RATE_HALF       2'b01
`define ATS_RATE_QUARTER    2'b10
`define ATS_RATE_RSVD       2'b11

`endif

// File: clockBank.sv
// rate prescaler and the sixteen counters with enable and rate state
`include "ats21_cfg.svh"

module clockBank (
  input  logic                                          clk_1x,
  input  logic                                          reset,
  input  logic                                          clockWrA,
  input  logic                                          clockWrB,
  input  ats21Pkg::instrWordT                           wordA,
  input  ats21Pkg::instrWordT                           wordB,
  output logic [`ATS_NUM_CLOCKS*`ATS_COUNT_WIDTH-1:0]   counts,
  output logic [`ATS_NUM_CLOCKS-1:0]                    tickNow
);

  logic [1:0]                  prescale;            // free running phase
  logic [`ATS_COUNT_WIDTH-1:0] countQ [`ATS_NUM_CLOCKS];
  ats21Pkg::rateT              rateQ  [`ATS_NUM_CLOCKS];
  logic [`ATS_NUM_CLOCKS-1:0]  enQ;
  logic [`ATS_NUM_CLOCKS-1:0]  loadA, loadB, enWrA, enWrB;
  logic [`ATS_NUM_CLOCKS-1:0]  anyWr;
  logic [`ATS_NUM_CLOCKS-1:0]  phaseHit;

  // per counter write decode
  always_comb begin
    for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
      loadA[i] = clockWrA && (wordA.clockView.op == ats21Pkg::setClock) &&
                 (wordA.clockView.clockNum == `ATS_CLOCK_SEL_WIDTH'(i));
      loadB[i] = clockWrB && (wordB.clockView.op == ats21Pkg::setClock) &&
                 (wordB.clockView.clockNum == `ATS_CLOCK_SEL_WIDTH'(i));
      enWrA[i] = clockWrA && (wordA.clockView.op == ats21Pkg::enableClock) &&
                 (wordA.clockView.clockNum == `ATS_CLOCK_SEL_WIDTH'(i));
      enWrB[i] = clockWrB && (wordB.clockView.op == ats21Pkg::enableClock) &&
                 (wordB.clockView.clockNum == `ATS_CLOCK_SEL_WIDTH'(i));
      anyWr[i] = loadA[i] | loadB[i] | enWrA[i] | enWrB[i];
    end
  end

  // tick decision, a write at this edge wins over the tick
  always_comb begin
    for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
      case (rateQ[i])
        ats21Pkg::rateEvery:   phaseHit[i] = 1'b1;
        ats21Pkg::rateHalf:    phaseHit[i] = prescale[0];
        ats21Pkg::rateQuarter: phaseHit[i] = &prescale;
        default:               phaseHit[i] = 1'b0;   // reserved code
      endcase
      tickNow[i] = enQ[i] && phaseHit[i] && !anyWr[i];
    end
  end

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      prescale <= '0;
      enQ      <= '0;
      for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
        countQ[i] <= '0;
        rateQ[i]  <= ats21Pkg::rateEvery;
      end
    end else begin
      prescale <= prescale + 2'd1;
      for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
        if (loadA[i]) begin               // load also starts the counter
          countQ[i] <= wordA.clockView.load;
          rateQ[i]  <= ats21Pkg::rateT'(wordA.clockView.rate);
          enQ[i]    <= 1'b1;
        end else if (loadB[i]) begin
          countQ[i] <= wordB.clockView.load;
          rateQ[i]  <= ats21Pkg::rateT'(wordB.clockView.rate);
          enQ[i]    <= 1'b1;
        end else if (enWrA[i]) begin
          enQ[i]    <= wordA.clockView.rate[1];   // enable sits on rate msb
        end else if (enWrB[i]) begin
          enQ[i]    <= wordB.clockView.rate[1];
        end else if (tickNow[i]) begin
          countQ[i] <= countQ[i] + 1'b1;
        end
      end
    end
  end

  for (genvar g = 0; g < `ATS_NUM_CLOCKS; g++) begin : genCounter
    assign counts[g*`ATS_COUNT_WIDTH +: `ATS_COUNT_WIDTH] = countQ[g];

    // reserved rate holds the count until rewritten
    rsvdFrozen : assert property (@(posedge clk_1x) disable iff (reset)
      (rateQ[g] == ats21Pkg::rateRsvd && !anyWr[g]) |=> $stable(countQ[g]));
  end

endmodule

// File: tbAts21Model.svh
// reference model: capture, status, prescaler, counters and alarm records
`ifndef TB_ATS21_MODEL_SVH
`define TB_ATS21_MODEL_SVH

logic [1:0]  mPend;                       // upper half waiting, per client
logic [15:0] mUpper [2];
logic [1:0]  mStat;
logic [1:0]  mPre;                        // prescaler phase
logic [15:0] mCount [`ATS_NUM_CLOCKS];
logic [1:0]  mRate  [`ATS_NUM_CLOCKS];
logic [`ATS_NUM_CLOCKS-1:0] mClkEn;
logic [`ATS_NUM_ALARMS-1:0] mAlmEn;
logic [`ATS_NUM_ALARMS-1:0] mRpt;
logic [3:0]  mSel   [`ATS_NUM_ALARMS];
logic [15:0] mTgt   [`ATS_NUM_ALARMS];
logic [1:0]  mHold  [`ATS_NUM_ALARMS];   // finish cycles left

task automatic modelReset();
  mPend  = '0;
  mStat  = '0;
  mPre   = '0;
  mClkEn = '0;
  mAlmEn = '0;
  mRpt   = '0;
  for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
    mCount[i] = '0;
    mRate[i]  = '0;
  end
  for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
    mSel[i]  = '0;
    mTgt[i]  = '0;
    mHold[i] = '0;
  end
endtask

function automatic logic [`ATS_NUM_ALARMS-1:0] modelData();
  logic [`ATS_NUM_ALARMS-1:0] d;
  for (int i = 0; i < `ATS_NUM_ALARMS; i++) d[i] = (mHold[i] != 0);
  return d;
endfunction

// one clock edge, inputs as seen just before it
task automatic modelStep(input logic rq, input logic [15:0] inA, input logic [15:0] inB);
  logic [15:0] half [2];
  logic [31:0] w    [2];
  logic [2:0]  op   [2];
  logic [1:0]  isClk;
  logic [1:0]  isAlm;
  logic [1:0]  acc;
  logic        conflict;
  logic        phase;
  logic [15:0] nxt;
  logic [`ATS_NUM_CLOCKS-1:0] wrClk;
  logic [`ATS_NUM_CLOCKS-1:0] tick;
  logic [`ATS_NUM_ALARMS-1:0] fire;
  int          n;
  half[0] = inA;
  half[1] = inB;
  wrClk   = '0;
  for (int c = 0; c < 2; c++) begin
    w[c]     = {mUpper[c], half[c]};
    op[c]    = w[c][31:29];
    isClk[c] = mPend[c] && (op[c] == 3'b001 || op[c] == 3'b010);
    isAlm[c] = mPend[c] && (op[c] >= 3'b101);
    if (mPend[c]) begin
      mPend[c] = 1'b0;                    // lower half taken
    end else if (rq && half[c][15:13] != 3'b000) begin
      mUpper[c] = half[c];
      mPend[c]  = 1'b1;
    end
  end
  conflict = (&isClk && w[0][28:25] == w[1][28:25]) ||
             (&isAlm && w[0][28:24] == w[1][28:24]);
  for (int c = 0; c < 2; c++) begin
    acc[c] = (isClk[c] || isAlm[c]) && !conflict;
    if (acc[c] && isClk[c]) wrClk[w[c][28:25]] = 1'b1;
  end
  mStat = acc;
  // which counters step this edge
  for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
    case (mRate[i])
      2'd0:    phase = 1'b1;
      2'd1:    phase = mPre[0];
      2'd2:    phase = (mPre == 2'd3);
      default: phase = 1'b0;
    endcase
    tick[i] = mClkEn[i] && phase && !wrClk[i];
  end
  // alarms use counts from before the edge
  for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
    nxt     = mCount[mSel[i]] + 16'd1;
    fire[i] = mAlmEn[i] && tick[mSel[i]] && (nxt == mTgt[i]);
    if (fire[i]) mHold[i] = `ATS_FINISH_HOLD;
    else if (mHold[i] != 0) mHold[i] = mHold[i] - 2'd1;
    if (fire[i] && !mRpt[i]) mAlmEn[i] = 1'b0;
  end
  for (int c = 0; c < 2; c++) begin
    n = w[c][28:24];
    if (acc[c] && isAlm[c] && n < `ATS_NUM_ALARMS) begin
      if (op[c] == 3'b111) begin
        mAlmEn[n] = w[c][23];
      end else begin
        mAlmEn[n] = 1'b1;
        mRpt[n]   = (op[c] == 3'b101) && w[c][23];
        mSel[n]   = w[c][19:16];
        mTgt[n]   = (op[c] == 3'b110) ? mCount[w[c][19:16]] + w[c][15:0] : w[c][15:0];
        mHold[n]  = '0;                   // set clears the finish bit
      end
    end
  end
  for (int i = 0; i < `ATS_NUM_CLOCKS; i++) begin
    if (tick[i]) mCount[i] = mCount[i] + 16'd1;
  end
  for (int c = 0; c < 2; c++) begin
    n = w[c][28:25];
    if (acc[c] && isClk[c]) begin
      if (op[c] == 3'b001) begin
        mCount[n] = w[c][15:0];
        mRate[n]  = w[c][23:22];
        mClkEn[n] = 1'b1;
      end else begin
        mClkEn[n] = w[c][23];
      end
    end
  end
  mPre = mPre + 2'd1;
endtask

`endif

// File: tbAts21.sv
// testbench top: clock, reset, LFSR, compare task, tests, timeout and summary
`include "ats21_cfg.svh"

module tbAts21;
  timeunit 1ns;
  timeprecision 100ps;

  // cycle budgets per test, init first, margin last
  localparam int CycleLimit = 100 + 150 + 150 + 700 + 250 + 250 + 450 + 200;

  logic        clk_1x;
  logic        reset;
  logic        req;
  logic [15:0] ctrlA;
  logic [15:0] ctrlB;
  logic [1:0]  stat;
  logic [`ATS_NUM_ALARMS-1:0] data;

  logic [15:0] lfsr = 16'd62531;
  string       testName = "init";
  bit          running = 0;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          testErrors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          rises [`ATS_NUM_ALARMS];   // DUT finish pulses seen
  logic [`ATS_NUM_ALARMS-1:0] prevData = '0;

  `include "tbAts21Model.svh"

  ats21Top dut (
    .clk_1x (clk_1x),
    .reset  (reset),
    .req    (req),
    .ctrlA  (ctrlA),
    .ctrlB  (ctrlB),
    .stat   (stat),
    .data   (data)
  );

  initial clk_1x = 1'b0;
  always #2 clk_1x = ~clk_1x;

  ////////////////////////////////////////////////////////////
  // model, monitor and timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk_1x or posedge reset) begin
    if (reset) modelReset();
    else modelStep(req, ctrlA, ctrlB);      // pre-edge inputs
  end

  always @(negedge clk_1x) begin
    if (!reset && running) begin
      check({testName, "/stat"}, mStat, stat);
      check({testName, "/data"}, modelData(), data);
      for (int i = 0; i < `ATS_NUM_ALARMS; i++) begin
        if (data[i] && !prevData[i]) rises[i]++;
      end
      prevData = data;
    end
  end

  always @(posedge clk_1x) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check(string name, logic [31:0] expVal, logic [31:0] actVal);
    checks++;
    if (expVal !== actVal) begin
      $display("Error: test %s expected %0h actual %0h", name, expVal, actVal);
      errors++;
      testErrors++;
    end
  endtask

  function automatic logic [31:0] clockWord(logic [2:0] op, int num, logic [1:0] rate,
                                            logic [15:0] load);
    return {op, 4'(num), 1'b0, rate, 6'b0, load};
  endfunction

  function automatic logic [31:0] alarmWord(logic [2:0] op, int num, logic rpt, int sel,
                                            logic [15:0] val);
    return {op, 5'(num), rpt, 3'b0, 4'(sel), val};
  endfunction

  // upper half, lower half, then idle; stat read after the execute edge
  task automatic sendPair(logic [31:0] a, logic [31:0] b, output logic [1:0] st);
    @(posedge clk_1x);
    req   <= 1'b1;
    ctrlA <= a[31:16];
    ctrlB <= b[31:16];
    @(posedge clk_1x);
    req   <= 1'b0;
    ctrlA <= a[15:0];
    ctrlB <= b[15:0];
    @(posedge clk_1x);
    ctrlA <= '0;
    ctrlB <= '0;
    @(negedge clk_1x);
    st = stat;
  endtask

  task automatic sendA(logic [31:0] a);
    logic [1:0] st;
    sendPair(a, 32'h0, st);
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge clk_1x);
  endtask

  task automatic waitFire(int idx, int limit);
    int n;
    n = 0;
    while (!data[idx] && n < limit) begin
      @(negedge clk_1x);
      n++;
    end
    if (!data[idx]) begin
      $display("test %s: alarm %0d did not fire within %0d cycles", testName, idx, limit);
      errors++;
      testErrors++;
    end
  endtask

  // read pulse counts away from the monitor edge
  task automatic checkRises(int idx, int expCount);
    @(posedge clk_1x);
    check($sformatf("%s/rises%0d", testName, idx), expCount, rises[idx]);
  endtask

  task automatic startTest(string name);
    @(posedge clk_1x);
    testName   = name;
    testErrors = 0;
    for (int i = 0; i < `ATS_NUM_ALARMS; i++) rises[i] = 0;
  endtask

  task automatic endTest();
    testsRun++;
    if (testErrors != 0) testsFailed++;
    $display("test %s finished with %0d errors", testName, testErrors);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [1:0]  st;
    logic [31:0] a;
    logic [31:0] b;
    logic [15:0] base [3];
    req   = 1'b0;
    ctrlA = '0;
    ctrlB = '0;
    reset = 1'b1;
    repeat (2) @(posedge clk_1x);
    reset <= 1'b0;
    @(negedge clk_1x);
    running = 1;

    // give every alarm a defined record, parked on idle counter 15
    for (int i = 0; i < `ATS_NUM_ALARMS / 2; i++) begin
      sendPair(alarmWord(3'b101, i, 1'b0, 15, 16'h0),
               alarmWord(3'b101, i + 12, 1'b0, 15, 16'h0), st);
    end

    startTest("status");
    for (int k = 0; k < 24; k++) begin
      a = randBits(32);
      b = randBits(32);
      if (k % 4 == 0) b[31:24] = a[31:24];  // provoke some same-target pairs
      sendPair(a, b, st);
    end
    endTest();

    startTest("conflict");
    sendA(alarmWord(3'b111, 20, 1'b0, 0, 16'h0));          // park alarm 20
    sendA(clockWord(3'b001, 3, 2'd0, 16'd0));
    sendA(clockWord(3'b010, 3, 2'b00, 16'd0));             // counter 3 stopped
    sendA(alarmWord(3'b101, 21, 1'b0, 3, 16'd15));         // armed on the stopped counter
    sendPair(clockWord(3'b001, 3, 2'd0, 16'd5), clockWord(3'b001, 3, 2'd1, 16'd9), st);
    check("conflict/clock", 2'b00, st);
    sendPair(alarmWord(3'b101, 20, 1'b0, 5, 16'd20), alarmWord(3'b101, 20, 1'b1, 5, 16'd20), st);
    check("conflict/alarm", 2'b00, st);
    sendPair(alarmWord(3'b101, 20, 1'b0, 5, 16'd20), alarmWord(3'b110, 20, 1'b0, 5, 16'd12), st);
    check("conflict/timer", 2'b00, st);
    sendA(clockWord(3'b001, 5, 2'd0, 16'd10));
    idle(40);
    checkRises(20, 0);
    checkRises(21, 0);
    endTest();

    startTest("rates");
    for (int r = 0; r < 3; r++) begin
      base[r] = 16'(randBits(16));
      sendA(clockWord(3'b001, r, 2'(r), base[r]));
    end
    for (int r = 0; r < 3; r++) begin
      sendA(alarmWord(3'b101, r, 1'b0, r, base[r] + 16'd40));
    end
    for (int r = 0; r < 3; r++) waitFire(r, 200);
    idle(4);
    for (int r = 0; r < 3; r++) checkRises(r, 1);
    endTest();

    startTest("timer");
    base[0] = 16'(randBits(16));
    sendA(clockWord(3'b001, 7, 2'd0, base[0]));
    sendA(alarmWord(3'b110, 10, 1'b1, 7, 16'd8 + 16'(randBits(4))));  // repeat bit set
    waitFire(10, 100);
    idle(4);
    sendA(clockWord(3'b001, 7, 2'd0, base[0]));            // run past the target again
    idle(60);
    checkRises(10, 1);
    endTest();

    startTest("repeat");
    sendA(clockWord(3'b001, 9, 2'd0, 16'd0));
    sendPair(alarmWord(3'b101, 11, 1'b1, 9, 16'd30), alarmWord(3'b101, 12, 1'b0, 9, 16'd30), st);
    waitFire(11, 100);
    idle(4);
    sendA(clockWord(3'b001, 9, 2'd0, 16'd10));
    waitFire(11, 60);
    idle(10);
    checkRises(11, 2);
    checkRises(12, 1);
    endTest();

    startTest("enable");
    sendA(clockWord(3'b001, 12, 2'd0, 16'd0));
    sendA(alarmWord(3'b101, 14, 1'b0, 12, 16'd50));
    sendA(clockWord(3'b010, 12, 2'b00, 16'd0));            // counter off, frozen
    idle(80);
    checkRises(14, 0);
    sendA(clockWord(3'b010, 12, 2'b10, 16'd0));            // counter back on
    waitFire(14, 100);
    idle(4);
    checkRises(14, 1);
    sendA(clockWord(3'b001, 12, 2'd0, 16'd0));
    sendA(alarmWord(3'b101, 15, 1'b0, 12, 16'd30));
    sendA(alarmWord(3'b111, 15, 1'b0, 0, 16'd0));          // alarm off
    idle(60);
    checkRises(15, 0);
    sendA(alarmWord(3'b111, 15, 1'b1, 0, 16'd0));
    sendA(clockWord(3'b001, 12, 2'd0, 16'd0));
    waitFire(15, 100);
    idle(4);
    checkRises(15, 1);
    endTest();

    running = 0;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
